// ==== src/raw_value_pkg.sv ====
// Shared widths and field positions for the unpacked adder words
// Operand and sum words both run sign, scale, fraction, inf, zero from the top down
package raw_value_pkg;

    localparam int FRAC_W      = 16;    // Fraction bits below the hidden one
    localparam int SCALE_W     = 8;     // Signed power of two
    localparam int SUM_SCALE_W = 9;     // One bit wider so a carry fits
    localparam int GUARD_W     = 3;
    localparam int ALIGN_W     = 1 + FRAC_W + GUARD_W;  // Hidden bit, fraction, guard bits
    localparam int DIFF_W      = 8;     // Unsigned scale difference
    localparam int LEAD_W      = 5;     // Leading one position in the raw sum
    localparam int RAW_W       = 1 + SCALE_W + FRAC_W + 2;
    localparam int SUM_RAW_W   = 1 + SUM_SCALE_W + FRAC_W + 2;

    // Operand word
    localparam int ZERO_BIT  = 0;
    localparam int INF_BIT   = 1;
    localparam int FRAC_LSB  = 2;
    localparam int FRAC_MSB  = FRAC_LSB + FRAC_W - 1;
    localparam int SCALE_LSB = FRAC_MSB + 1;
    localparam int SCALE_MSB = SCALE_LSB + SCALE_W - 1;
    localparam int SGN_BIT   = SCALE_MSB + 1;

    // Sum word keeps fraction and flags where the operand has them
    localparam int SUM_SCALE_LSB = FRAC_MSB + 1;
    localparam int SUM_SCALE_MSB = SUM_SCALE_LSB + SUM_SCALE_W - 1;
    localparam int SUM_SGN_BIT   = SUM_SCALE_MSB + 1;

endpackage

// ==== src/operand_order_stage.sv ====
// Adder stage 1
// Registers and unpacks both operands, then orders them by magnitude
`timescale 1ns/10ps

module operand_order_stage (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     start,
    input  logic [raw_value_pkg::RAW_W-1:0]          in1,
    input  logic [raw_value_pkg::RAW_W-1:0]          in2,
    input  logic                                     in1_truncated,
    input  logic                                     in2_truncated,
    output logic                                     valid,
    output logic                                     add_op,
    output logic                                     hi_sgn,
    output logic signed [raw_value_pkg::SCALE_W-1:0] hi_scale,
    output logic [raw_value_pkg::FRAC_W-1:0]         hi_fraction,
    output logic                                     hi_inf,
    output logic                                     hi_zero,
    output logic [raw_value_pkg::FRAC_W-1:0]         low_fraction,
    output logic                                     low_inf,
    output logic                                     low_zero,
    output logic [raw_value_pkg::DIFF_W-1:0]         scale_diff,
    output logic                                     in_truncated
);

    logic                                     r_valid;
    logic                                     r_a_sgn;
    logic signed [raw_value_pkg::SCALE_W-1:0] r_a_scale;
    logic [raw_value_pkg::FRAC_W-1:0]         r_a_frac;
    logic                                     r_a_inf;
    logic                                     r_a_zero;
    logic                                     r_a_trunc;
    logic                                     r_b_sgn;
    logic signed [raw_value_pkg::SCALE_W-1:0] r_b_scale;
    logic [raw_value_pkg::FRAC_W-1:0]         r_b_frac;
    logic                                     r_b_inf;
    logic                                     r_b_zero;
    logic                                     r_b_trunc;
    logic                                     a_keep;
    logic                                     b_keep;
    logic                                     a_is_hi;
    logic signed [raw_value_pkg::SCALE_W-1:0] low_scale;

    assign a_keep = ~in1[raw_value_pkg::ZERO_BIT];
    assign b_keep = ~in2[raw_value_pkg::ZERO_BIT];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r_valid <= 1'b0;
        else
            r_valid <= start;
    end

    // A zero operand enters with every other field cleared
    always_ff @(posedge clk)
    begin
        r_a_zero  <= in1[raw_value_pkg::ZERO_BIT];
        r_a_sgn   <= in1[raw_value_pkg::SGN_BIT] & a_keep;
        r_a_scale <= in1[raw_value_pkg::SCALE_MSB:raw_value_pkg::SCALE_LSB]
                     & {raw_value_pkg::SCALE_W{a_keep}};
        r_a_frac  <= in1[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB]
                     & {raw_value_pkg::FRAC_W{a_keep}};
        r_a_inf   <= in1[raw_value_pkg::INF_BIT] & a_keep;
        r_a_trunc <= in1_truncated & a_keep;
        r_b_zero  <= in2[raw_value_pkg::ZERO_BIT];
        r_b_sgn   <= in2[raw_value_pkg::SGN_BIT] & b_keep;
        r_b_scale <= in2[raw_value_pkg::SCALE_MSB:raw_value_pkg::SCALE_LSB]
                     & {raw_value_pkg::SCALE_W{b_keep}};
        r_b_frac  <= in2[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB]
                     & {raw_value_pkg::FRAC_W{b_keep}};
        r_b_inf   <= in2[raw_value_pkg::INF_BIT] & b_keep;
        r_b_trunc <= in2_truncated & b_keep;
    end

    // Scale decides first, fraction breaks the tie, in1 wins a full tie
    assign a_is_hi = r_b_zero ? 1'b1 :
                     r_a_zero ? 1'b0 :
                     (r_a_scale != r_b_scale) ? (r_a_scale > r_b_scale) :
                     (r_a_frac >= r_b_frac);

    assign valid        = r_valid;
    assign add_op       = ~(r_a_sgn ^ r_b_sgn);    // Equal signs add
    assign hi_sgn       = a_is_hi ? r_a_sgn : r_b_sgn;
    assign hi_scale     = a_is_hi ? r_a_scale : r_b_scale;
    assign hi_fraction  = a_is_hi ? r_a_frac : r_b_frac;
    assign hi_inf       = a_is_hi ? r_a_inf : r_b_inf;
    assign hi_zero      = a_is_hi ? r_a_zero : r_b_zero;
    assign low_scale    = a_is_hi ? r_b_scale : r_a_scale;
    assign low_fraction = a_is_hi ? r_b_frac : r_a_frac;
    assign low_inf      = a_is_hi ? r_b_inf : r_a_inf;
    assign low_zero     = a_is_hi ? r_b_zero : r_a_zero;
    assign scale_diff   = hi_scale - low_scale;     // Never negative once ordered
    assign in_truncated = r_a_trunc | r_b_trunc;

endmodule

// ==== src/align_add_stage.sv ====
// Adder stage 2
// Aligns the low mantissa to the high one, adds or subtracts, gathers lost bits
`timescale 1ns/10ps

module align_add_stage (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     s1_valid,
    input  logic                                     s1_add_op,
    input  logic                                     s1_hi_sgn,
    input  logic signed [raw_value_pkg::SCALE_W-1:0] s1_hi_scale,
    input  logic [raw_value_pkg::FRAC_W-1:0]         s1_hi_fraction,
    input  logic                                     s1_hi_inf,
    input  logic                                     s1_hi_zero,
    input  logic [raw_value_pkg::FRAC_W-1:0]         s1_low_fraction,
    input  logic                                     s1_low_inf,
    input  logic                                     s1_low_zero,
    input  logic [raw_value_pkg::DIFF_W-1:0]         s1_scale_diff,
    input  logic                                     s1_in_truncated,
    output logic                                     valid,
    output logic [raw_value_pkg::ALIGN_W:0]          sum_raw,
    output logic                                     sgn,
    output logic signed [raw_value_pkg::SCALE_W-1:0] hi_scale,
    output logic                                     zero,
    output logic                                     inf,
    output logic                                     truncated
);

    logic                                     r_valid;
    logic                                     r_add_op;
    logic                                     r_hi_sgn;
    logic signed [raw_value_pkg::SCALE_W-1:0] r_hi_scale;
    logic [raw_value_pkg::FRAC_W-1:0]         r_hi_fraction;
    logic                                     r_hi_inf;
    logic                                     r_hi_zero;
    logic [raw_value_pkg::FRAC_W-1:0]         r_low_fraction;
    logic                                     r_low_inf;
    logic                                     r_low_zero;
    logic [raw_value_pkg::DIFF_W-1:0]         r_scale_diff;
    logic                                     r_in_truncated;
    logic [raw_value_pkg::ALIGN_W-1:0]        hi_mant;
    logic [raw_value_pkg::ALIGN_W-1:0]        low_mant;
    logic [2*raw_value_pkg::ALIGN_W-1:0]      window;
    logic [raw_value_pkg::ALIGN_W-1:0]        low_aligned;
    logic                                     past_window;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r_valid <= 1'b0;
        else
            r_valid <= s1_valid;
    end

    always_ff @(posedge clk)
    begin
        r_add_op       <= s1_add_op;
        r_hi_sgn       <= s1_hi_sgn;
        r_hi_scale     <= s1_hi_scale;
        r_hi_fraction  <= s1_hi_fraction;
        r_hi_inf       <= s1_hi_inf;
        r_hi_zero      <= s1_hi_zero;
        r_low_fraction <= s1_low_fraction;
        r_low_inf      <= s1_low_inf;
        r_low_zero     <= s1_low_zero;
        r_scale_diff   <= s1_scale_diff;
        r_in_truncated <= s1_in_truncated;
    end

    assign hi_mant  = {~r_hi_zero, r_hi_fraction, {raw_value_pkg::GUARD_W{1'b0}}};
    assign low_mant = {~r_low_zero, r_low_fraction, {raw_value_pkg::GUARD_W{1'b0}}};

    // Upper half lines up with hi, lower half keeps what falls off
    assign window      = {low_mant, {raw_value_pkg::ALIGN_W{1'b0}}} >> r_scale_diff;
    assign low_aligned = window[2*raw_value_pkg::ALIGN_W-1:raw_value_pkg::ALIGN_W];
    assign past_window = (int'(r_scale_diff) >= 2 * raw_value_pkg::ALIGN_W) & ~r_low_zero;

    // Ordering keeps the difference non negative
    assign sum_raw = r_add_op ? {1'b0, hi_mant} + {1'b0, low_aligned}
                              : {1'b0, hi_mant} - {1'b0, low_aligned};

    assign truncated = |window[raw_value_pkg::ALIGN_W-1:0] | past_window | r_in_truncated;
    assign valid     = r_valid;
    assign sgn       = r_hi_sgn;                   // Result follows hi
    assign hi_scale  = r_hi_scale;
    assign zero      = r_hi_zero & r_low_zero;
    assign inf       = r_hi_inf | r_low_inf;

endmodule

// ==== src/lead_one_stage.sv ====
// Adder stage 3
// Locates the leading one of the raw sum and derives the result scale
`timescale 1ns/10ps

module lead_one_stage (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         s2_valid,
    input  logic [raw_value_pkg::ALIGN_W:0]              s2_sum_raw,
    input  logic                                         s2_sgn,
    input  logic signed [raw_value_pkg::SCALE_W-1:0]     s2_hi_scale,
    input  logic                                         s2_zero,
    input  logic                                         s2_inf,
    input  logic                                         s2_truncated,
    output logic                                         valid,
    output logic [raw_value_pkg::ALIGN_W:0]              sum_raw,
    output logic [raw_value_pkg::LEAD_W-1:0]             lead_pos,
    output logic                                         sgn,
    output logic signed [raw_value_pkg::SUM_SCALE_W-1:0] scale,
    output logic                                         zero,
    output logic                                         inf,
    output logic                                         truncated
);

    logic                                     r_valid;
    logic [raw_value_pkg::ALIGN_W:0]          r_sum_raw;
    logic                                     r_sgn;
    logic signed [raw_value_pkg::SCALE_W-1:0] r_hi_scale;
    logic                                     r_zero;
    logic                                     r_inf;
    logic                                     r_truncated;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r_valid <= 1'b0;
        else
            r_valid <= s2_valid;
    end

    always_ff @(posedge clk)
    begin
        r_sum_raw   <= s2_sum_raw;
        r_sgn       <= s2_sgn;
        r_hi_scale  <= s2_hi_scale;
        r_zero      <= s2_zero;
        r_inf       <= s2_inf;
        r_truncated <= s2_truncated;
    end

    // Priority search where the highest set bit is written last
    always_comb
    begin
        int pos;
        pos = 0;
        for (int i = 0; i <= raw_value_pkg::ALIGN_W; i++)
        begin
            if (r_sum_raw[i])
                pos = raw_value_pkg::ALIGN_W - i;  // Counted down from the carry bit
        end
        lead_pos = pos[raw_value_pkg::LEAD_W-1:0];
    end

    // Carry bit set gives hi scale + 1
    assign scale = {{(raw_value_pkg::SUM_SCALE_W-raw_value_pkg::SCALE_W)
                     {r_hi_scale[raw_value_pkg::SCALE_W-1]}}, r_hi_scale}
                   + {{(raw_value_pkg::SUM_SCALE_W-1){1'b0}}, 1'b1}
                   - {{(raw_value_pkg::SUM_SCALE_W-raw_value_pkg::LEAD_W){1'b0}}, lead_pos};

    assign valid     = r_valid;
    assign sum_raw   = r_sum_raw;
    assign sgn       = r_sgn;
    assign zero      = r_zero;
    assign inf       = r_inf;
    assign truncated = r_truncated;

endmodule

// ==== src/normalize_stage.sv ====
// Adder stage 4
// Shifts the sum up past its leading one and packs the result word
`timescale 1ns/10ps

module normalize_stage (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         s3_valid,
    input  logic [raw_value_pkg::ALIGN_W:0]              s3_sum_raw,
    input  logic [raw_value_pkg::LEAD_W-1:0]             s3_lead_pos,
    input  logic                                         s3_sgn,
    input  logic signed [raw_value_pkg::SUM_SCALE_W-1:0] s3_scale,
    input  logic                                         s3_zero,
    input  logic                                         s3_inf,
    input  logic                                         s3_truncated,
    output logic                                         done,
    output logic [raw_value_pkg::SUM_RAW_W-1:0]          result,
    output logic                                         truncated
);

    logic                                         r_valid;
    logic [raw_value_pkg::ALIGN_W:0]              r_sum_raw;
    logic [raw_value_pkg::LEAD_W-1:0]             r_lead_pos;
    logic                                         r_sgn;
    logic signed [raw_value_pkg::SUM_SCALE_W-1:0] r_scale;
    logic                                         r_zero;
    logic                                         r_inf;
    logic                                         r_truncated;
    logic [raw_value_pkg::LEAD_W-1:0]             shift_amt;
    logic [raw_value_pkg::ALIGN_W:0]              norm;
    logic                                         res_zero;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            r_valid <= 1'b0;
        else
            r_valid <= s3_valid;
    end

    always_ff @(posedge clk)
    begin
        r_sum_raw   <= s3_sum_raw;
        r_lead_pos  <= s3_lead_pos;
        r_sgn       <= s3_sgn;
        r_scale     <= s3_scale;
        r_zero      <= s3_zero;
        r_inf       <= s3_inf;
        r_truncated <= s3_truncated;
    end

    // One more drops the hidden bit
    assign shift_amt = r_lead_pos + {{(raw_value_pkg::LEAD_W-1){1'b0}}, 1'b1};
    assign norm      = r_sum_raw << shift_amt;
    assign res_zero  = (r_zero | ~|r_sum_raw) & ~r_inf;   // Cancelled sum is zero unless inf

    always_comb
    begin
        result = '0;
        result[raw_value_pkg::SUM_SGN_BIT] = r_sgn;
        if (!res_zero)
        begin
            result[raw_value_pkg::SUM_SCALE_MSB:raw_value_pkg::SUM_SCALE_LSB] = r_scale;
            result[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB] =
                norm[raw_value_pkg::ALIGN_W -: raw_value_pkg::FRAC_W];
        end
        result[raw_value_pkg::INF_BIT]  = r_inf;
        result[raw_value_pkg::ZERO_BIT] = res_zero;
    end

    assign done      = r_valid;
    assign truncated = r_truncated;

endmodule

// ==== src/raw_adder_top.sv ====
// Four stage adder for unpacked floating values
// Order, align and add, find the leading one, normalize
`timescale 1ns/10ps

module raw_adder_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [raw_value_pkg::RAW_W-1:0]     in1,
    input  logic [raw_value_pkg::RAW_W-1:0]     in2,
    input  logic                                in1_truncated,
    input  logic                                in2_truncated,
    output logic [raw_value_pkg::SUM_RAW_W-1:0] result,
    output logic                                done,
    output logic                                truncated
);

    // Stage 1 to stage 2
    logic                                         s1_valid;
    logic                                         s1_add_op;
    logic                                         s1_hi_sgn;
    logic signed [raw_value_pkg::SCALE_W-1:0]     s1_hi_scale;
    logic [raw_value_pkg::FRAC_W-1:0]             s1_hi_fraction;
    logic                                         s1_hi_inf;
    logic                                         s1_hi_zero;
    logic [raw_value_pkg::FRAC_W-1:0]             s1_low_fraction;
    logic                                         s1_low_inf;
    logic                                         s1_low_zero;
    logic [raw_value_pkg::DIFF_W-1:0]             s1_scale_diff;
    logic                                         s1_in_truncated;
    // Stage 2 to stage 3
    logic                                         s2_valid;
    logic [raw_value_pkg::ALIGN_W:0]              s2_sum_raw;
    logic                                         s2_sgn;
    logic signed [raw_value_pkg::SCALE_W-1:0]     s2_hi_scale;
    logic                                         s2_zero;
    logic                                         s2_inf;
    logic                                         s2_truncated;
    // Stage 3 to stage 4
    logic                                         s3_valid;
    logic [raw_value_pkg::ALIGN_W:0]              s3_sum_raw;
    logic [raw_value_pkg::LEAD_W-1:0]             s3_lead_pos;
    logic                                         s3_sgn;
    logic signed [raw_value_pkg::SUM_SCALE_W-1:0] s3_scale;
    logic                                         s3_zero;
    logic                                         s3_inf;
    logic                                         s3_truncated;

    operand_order_stage u_order (
        .clk(clk), .rst_n(rst_n), .start(start),
        .in1(in1), .in2(in2),
        .in1_truncated(in1_truncated), .in2_truncated(in2_truncated),
        .valid(s1_valid), .add_op(s1_add_op),
        .hi_sgn(s1_hi_sgn), .hi_scale(s1_hi_scale), .hi_fraction(s1_hi_fraction),
        .hi_inf(s1_hi_inf), .hi_zero(s1_hi_zero),
        .low_fraction(s1_low_fraction), .low_inf(s1_low_inf), .low_zero(s1_low_zero),
        .scale_diff(s1_scale_diff), .in_truncated(s1_in_truncated)
    );

    align_add_stage u_align (
        .clk(clk), .rst_n(rst_n),
        .s1_valid(s1_valid), .s1_add_op(s1_add_op),
        .s1_hi_sgn(s1_hi_sgn), .s1_hi_scale(s1_hi_scale), .s1_hi_fraction(s1_hi_fraction),
        .s1_hi_inf(s1_hi_inf), .s1_hi_zero(s1_hi_zero),
        .s1_low_fraction(s1_low_fraction), .s1_low_inf(s1_low_inf),
        .s1_low_zero(s1_low_zero), .s1_scale_diff(s1_scale_diff),
        .s1_in_truncated(s1_in_truncated),
        .valid(s2_valid), .sum_raw(s2_sum_raw), .sgn(s2_sgn), .hi_scale(s2_hi_scale),
        .zero(s2_zero), .inf(s2_inf), .truncated(s2_truncated)
    );

    lead_one_stage u_lead (
        .clk(clk), .rst_n(rst_n),
        .s2_valid(s2_valid), .s2_sum_raw(s2_sum_raw), .s2_sgn(s2_sgn),
        .s2_hi_scale(s2_hi_scale), .s2_zero(s2_zero), .s2_inf(s2_inf),
        .s2_truncated(s2_truncated),
        .valid(s3_valid), .sum_raw(s3_sum_raw), .lead_pos(s3_lead_pos), .sgn(s3_sgn),
        .scale(s3_scale), .zero(s3_zero), .inf(s3_inf), .truncated(s3_truncated)
    );

    normalize_stage u_norm (
        .clk(clk), .rst_n(rst_n),
        .s3_valid(s3_valid), .s3_sum_raw(s3_sum_raw), .s3_lead_pos(s3_lead_pos),
        .s3_sgn(s3_sgn), .s3_scale(s3_scale), .s3_zero(s3_zero), .s3_inf(s3_inf),
        .s3_truncated(s3_truncated),
        .done(done), .result(result), .truncated(truncated)
    );

endmodule

// ==== tests/raw_adder_assertions.sv ====
// Protocol checks on the adder top level
`timescale 1ns/10ps

module raw_adder_assertions (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                start,
    input logic                                done,
    input logic [raw_value_pkg::SUM_RAW_W-1:0] result
);

    logic [2:0] settled;    // Edges since reset, stops at four

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            settled <= '0;
        else if (settled != 3'd4)
            settled <= settled + 3'd1;
    end

    done_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !done)
        else $error("done high while reset is asserted");

    // Four registers between start and done
    done_follows_start: assert property (@(posedge clk) disable iff (!rst_n)
        (settled == 3'd4) |-> (done == $past(start, 4)))
        else $error("done does not match start from four cycles earlier");

    inf_zero_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !(result[raw_value_pkg::INF_BIT] && result[raw_value_pkg::ZERO_BIT]))
        else $error("result has both inf and zero set");

endmodule

bind raw_adder_top raw_adder_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .start(start), .done(done), .result(result)
);

// ==== tests/raw_adder_tb.sv ====
// Testbench for the four stage raw value adder
// Directed and random operands checked in issue order against a reference model
`timescale 1ns/10ps

module raw_adder_tb;

    localparam int NUM_RANDOM      = 40;
    localparam int MAX_GAP         = 3;
    localparam int NUM_OPS         = 11 + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_OPS * (MAX_GAP + 1) + 20;

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic [raw_value_pkg::RAW_W-1:0]     in1;
    logic [raw_value_pkg::RAW_W-1:0]     in2;
    logic                                in1_truncated;
    logic                                in2_truncated;
    logic [raw_value_pkg::SUM_RAW_W-1:0] result;
    logic                                done;
    logic                                truncated;
    logic [raw_value_pkg::SUM_RAW_W-1:0] exp_result_q[$];
    logic                                exp_trunc_q[$];
    int                                  seed;

    raw_adder_top u_raw_adder_top (
        .clk(clk), .rst_n(rst_n), .start(start), .in1(in1), .in2(in2),
        .in1_truncated(in1_truncated), .in2_truncated(in2_truncated),
        .result(result), .done(done), .truncated(truncated)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "Stopping at the first error");
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout, %0d operations still waiting for done", exp_result_q.size());
        fail_run();
    end

    function automatic logic [raw_value_pkg::RAW_W-1:0] pack_op(input logic sgn, input int scale,
        input int frac, input logic inf, input logic zero);
        logic [raw_value_pkg::RAW_W-1:0] w;
        w = '0;
        w[raw_value_pkg::SGN_BIT] = sgn;
        w[raw_value_pkg::SCALE_MSB:raw_value_pkg::SCALE_LSB] = scale[raw_value_pkg::SCALE_W-1:0];
        w[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB]   = frac[raw_value_pkg::FRAC_W-1:0];
        w[raw_value_pkg::INF_BIT]  = inf;
        w[raw_value_pkg::ZERO_BIT] = zero;
        return w;
    endfunction

    // Expected sum word and truncated flag with truncation toward zero
    function automatic logic [raw_value_pkg::SUM_RAW_W-1:0] ref_add(
        input logic [raw_value_pkg::RAW_W-1:0] a, input logic [raw_value_pkg::RAW_W-1:0] b,
        input logic a_trunc, input logic b_trunc, output logic exp_trunc);
        logic                                a_zero;
        logic                                b_zero;
        logic                                a_sgn;
        logic                                b_sgn;
        logic                                a_hi;
        logic                                res_inf;
        logic                                res_zero;
        int                                  a_scale;
        int                                  b_scale;
        int                                  a_mant;
        int                                  b_mant;
        int                                  hi_scale;
        int                                  hi_mant;
        int                                  lo_mant;
        int                                  lo_aligned;
        int                                  diff;
        int                                  sum;
        int                                  norm;
        int                                  p;
        int                                  frac;
        int                                  res_scale;
        logic [raw_value_pkg::SUM_RAW_W-1:0] res;
        a_zero  = a[raw_value_pkg::ZERO_BIT];
        b_zero  = b[raw_value_pkg::ZERO_BIT];
        a_sgn   = a[raw_value_pkg::SGN_BIT] & ~a_zero;   // Zero operand counts as +0
        b_sgn   = b[raw_value_pkg::SGN_BIT] & ~b_zero;
        a_scale = a_zero ? 0 : int'($signed(a[raw_value_pkg::SCALE_MSB:raw_value_pkg::SCALE_LSB]));
        b_scale = b_zero ? 0 : int'($signed(b[raw_value_pkg::SCALE_MSB:raw_value_pkg::SCALE_LSB]));
        a_mant  = a_zero ? 0 : (int'(a[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB])
                  + (1 << raw_value_pkg::FRAC_W)) << raw_value_pkg::GUARD_W;
        b_mant  = b_zero ? 0 : (int'(b[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB])
                  + (1 << raw_value_pkg::FRAC_W)) << raw_value_pkg::GUARD_W;
        if (b_zero)
            a_hi = 1'b1;
        else if (a_zero)
            a_hi = 1'b0;
        else if (a_scale != b_scale)
            a_hi = (a_scale > b_scale);
        else
            a_hi = (a_mant >= b_mant);
        hi_scale   = a_hi ? a_scale : b_scale;
        hi_mant    = a_hi ? a_mant : b_mant;
        lo_mant    = a_hi ? b_mant : a_mant;
        diff       = a_hi ? a_scale - b_scale : b_scale - a_scale;
        lo_aligned = lo_mant >> diff;
        exp_trunc  = ((lo_aligned << diff) != lo_mant) | (a_trunc & ~a_zero) | (b_trunc & ~b_zero);
        sum        = (a_sgn == b_sgn) ? hi_mant + lo_aligned : hi_mant - lo_aligned;
        // Move the leading one up to the carry position
        norm = sum;
        p    = 0;
        while (norm != 0 && norm < (1 << raw_value_pkg::ALIGN_W))
        begin
            norm = norm << 1;
            p++;
        end
        frac      = (norm >> (raw_value_pkg::ALIGN_W - raw_value_pkg::FRAC_W))
                    & ((1 << raw_value_pkg::FRAC_W) - 1);
        res_scale = hi_scale + 1 - p;
        res_inf   = (a[raw_value_pkg::INF_BIT] & ~a_zero) | (b[raw_value_pkg::INF_BIT] & ~b_zero);
        res_zero  = (sum == 0) && !res_inf;
        res = '0;
        res[raw_value_pkg::SUM_SGN_BIT] = a_hi ? a_sgn : b_sgn;
        if (!res_zero)
        begin
            res[raw_value_pkg::SUM_SCALE_MSB:raw_value_pkg::SUM_SCALE_LSB] =
                res_scale[raw_value_pkg::SUM_SCALE_W-1:0];
            res[raw_value_pkg::FRAC_MSB:raw_value_pkg::FRAC_LSB] = frac[raw_value_pkg::FRAC_W-1:0];
        end
        res[raw_value_pkg::INF_BIT]  = res_inf;
        res[raw_value_pkg::ZERO_BIT] = res_zero;
        return res;
    endfunction

    function automatic logic [raw_value_pkg::RAW_W-1:0] random_op();
        int word;
        int ctl;
        int scale;
        word = $random(seed);
        ctl  = $random(seed);
        if (ctl[2:0] == 3'd0)
            scale = int'($signed(ctl[15:8]));   // Occasional wide scale gap
        else
            scale = int'($signed(ctl[11:8]));   // Mostly close scales
        return pack_op(word[31], scale, word, ctl[5:3] == 3'd7, ctl[18:16] == 3'd0);
    endfunction

    task automatic check_result(input logic [raw_value_pkg::SUM_RAW_W-1:0] got,
        input logic [raw_value_pkg::SUM_RAW_W-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0d ns: result %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_truncated(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %0d ns: truncated %b, expected %b", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic send_op(input logic [raw_value_pkg::RAW_W-1:0] a,
        input logic [raw_value_pkg::RAW_W-1:0] b, input logic t1, input logic t2);
        logic [raw_value_pkg::SUM_RAW_W-1:0] exp_r;
        logic                                exp_t;
        @(posedge clk);
        #5;
        start         = 1'b1;
        in1           = a;
        in2           = b;
        in1_truncated = t1;
        in2_truncated = t2;
        exp_r = ref_add(a, b, t1, t2, exp_t);
        exp_result_q.push_back(exp_r);
        exp_trunc_q.push_back(exp_t);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #5;
            start = 1'b0;
        end
    endtask

    // Results are sampled mid cycle, away from the register edge
    always @(negedge clk)
    begin
        if (rst_n && done)
        begin
            if (exp_result_q.size() == 0)
            begin
                $display("A done arrived at %0d ns with no operation outstanding", $time);
                fail_run();
            end
            else
            begin
                check_result(result, exp_result_q.pop_front());
                check_truncated(truncated, exp_trunc_q.pop_front());
            end
        end
    end

    initial
    begin
        logic [raw_value_pkg::RAW_W-1:0] op_a;
        logic [raw_value_pkg::RAW_W-1:0] op_b;
        int                              flags;
        int                              waited;
        seed          = 98;
        rst_n         = 1'b0;
        start         = 1'b0;
        in1           = '0;
        in2           = '0;
        in1_truncated = 1'b0;
        in2_truncated = 1'b0;
        repeat (2) @(posedge clk);
        #5 rst_n = 1'b1;
        send_op(pack_op(1'b0, 3, 'h8000, 1'b0, 1'b0), pack_op(1'b0, 3, 'h8000, 1'b0, 1'b0),
                1'b0, 1'b0);   // Mantissa carry
        send_op(pack_op(1'b0, 5, 'h1234, 1'b0, 1'b0), pack_op(1'b0, 2, 'h4000, 1'b0, 1'b0),
                1'b0, 1'b0);
        send_op(pack_op(1'b1, -4, 'hF000, 1'b0, 1'b0), pack_op(1'b1, -4, 'hF000, 1'b0, 1'b0),
                1'b0, 1'b0);
        send_op(pack_op(1'b0, 2, 'h0010, 1'b0, 1'b0), pack_op(1'b1, 2, 'h0000, 1'b0, 1'b0),
                1'b0, 1'b0);   // Deep renormalize
        send_op(pack_op(1'b0, -3, 'hABCD, 1'b0, 1'b0), pack_op(1'b1, -3, 'hABCD, 1'b0, 1'b0),
                1'b0, 1'b0);   // Exact cancel
        send_op(pack_op(1'b1, 7, 'hFFFF, 1'b1, 1'b1), pack_op(1'b1, -5, 'h2222, 1'b0, 1'b0),
                1'b1, 1'b0);
        send_op(pack_op(1'b0, 4, 'h1000, 1'b1, 1'b0), pack_op(1'b1, 1, 'h0000, 1'b0, 1'b0),
                1'b0, 1'b0);
        send_op(pack_op(1'b0, 10, 'h0001, 1'b0, 1'b0), pack_op(1'b0, 0, 'h0003, 1'b0, 1'b0),
                1'b0, 1'b0);
        send_op(pack_op(1'b0, 100, 'h5555, 1'b0, 1'b0), pack_op(1'b1, -100, 'hFFFF, 1'b0, 1'b0),
                1'b0, 1'b0);   // Low operand falls past the window
        send_op(pack_op(1'b0, 1, 'h0000, 1'b0, 1'b0), pack_op(1'b0, 1, 'h0000, 1'b0, 1'b0),
                1'b1, 1'b1);
        send_op(pack_op(1'b1, 9, 'h0F0F, 1'b0, 1'b1), pack_op(1'b0, -9, 'h7777, 1'b1, 1'b1),
                1'b0, 1'b1);
        idle_cycles(2);
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            op_a  = random_op();
            op_b  = random_op();
            flags = $random(seed);
            send_op(op_a, op_b, flags[0] & flags[1], flags[2] & flags[3]);
            if (i >= NUM_RANDOM / 2)
                idle_cycles($unsigned($random(seed)) % (MAX_GAP + 1));
        end
        idle_cycles(1);
        waited = 0;
        while (exp_result_q.size() != 0 && waited < 10)
        begin
            @(posedge clk);
            waited++;
        end
        idle_cycles(4);   // Catch a stray done
        if (exp_result_q.size() != 0)
        begin
            $display("%0d operations never returned a result", exp_result_q.size());
            fail_run();
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
src/raw_value_pkg.sv
src/operand_order_stage.sv
src/align_add_stage.sv
src/lead_one_stage.sv
src/normalize_stage.sv
src/raw_adder_top.sv
tests/raw_adder_assertions.sv
tests/raw_adder_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the raw adder testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f \
    --top-module raw_adder_tb -o raw_adder_sim > build.log 2>&1 &&
    ./obj_dir/raw_adder_sim > sim.log 2>&1
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
